// File: Bender.yml
package:
  name: cpu8

sources:
  - include_dirs:
      - include
    files:
      - hw/cpu8_pkg.sv
      - hw/cpu8_alu.sv
      - hw/cpu8_core.sv
      - hw/cpu8_ram.sv
      - hw/cpu8_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/cpu8_props.sv
      - sim/cpu8_tb.sv

// File: hw/cpu8_alu.sv
// combinational ALU of the CPU, sixteen operations with a carry/borrow bit on top of the result
`timescale 1ns/1ps
`include "cpu8_config.svh"

module cpu8_alu #(
	parameter int width = `CPU8_DATA_W
) (
	input  logic [width-1:0] a,
	input  logic [width-1:0] b,
	input  logic             carry_in,
	input  cpu8_pkg::alu_op_e op,
	output logic [width:0]   result
);
	import cpu8_pkg::*;

	always_comb begin
		case (op)
			// plain unary ops, top bit stays clear
			alu_zero:   result = '0;
			alu_load_a: result = {1'b0, a};
			alu_inc:    result = {1'b0, a + 1'b1};
			alu_dec:    result = {1'b0, a - 1'b1};
			// shifts and rotates, outgoing bit lands on top
			alu_asl:    result = {a, 1'b0};
			alu_lsr:    result = {a[0], 1'b0, a[width-1:1]};
			alu_rol:    result = {a, carry_in};
			alu_ror:    result = {a[0], carry_in, a[width-1:1]};
			// logic ops
			alu_or:     result = {1'b0, a | b};
			alu_and:    result = {1'b0, a & b};
			alu_xor:    result = {1'b0, a ^ b};
			alu_load_b: result = {1'b0, b};
			// arithmetic, top bit is carry or borrow
			alu_add:    result = {1'b0, a} + {1'b0, b};
			alu_sub:    result = {1'b0, a} - {1'b0, b};
			alu_adc:    result = {1'b0, a} + {1'b0, b} + carry_in;
			alu_sbb:    result = {1'b0, a} - {1'b0, b} - carry_in;
			default:    result = '0;
		endcase
	end

endmodule

// File: hw/cpu8_core.sv
// CPU sequencer; fetches, decodes and executes one instruction byte at a time over the RAM bus
`timescale 1ns/1ps
`include "cpu8_config.svh"

module cpu8_core (
	input  logic                    clk,
	input  logic                    reset,
	input  logic [`CPU8_DATA_W-1:0] rdata,
	output logic [`CPU8_DATA_W-1:0] addr,
	output logic [`CPU8_DATA_W-1:0] wdata,
	output logic                    we,
	output logic [`CPU8_DATA_W-1:0] alu_a,
	output logic [`CPU8_DATA_W-1:0] alu_b,
	output logic                    alu_carry,
	output cpu8_pkg::alu_op_e       alu_op,
	input  logic [`CPU8_DATA_W:0]   alu_result
);
	import cpu8_pkg::*;

	logic [`CPU8_DATA_W-1:0] ip;
	logic [`CPU8_DATA_W-1:0] a;
	logic [`CPU8_DATA_W-1:0] b;
	logic                    zero;
	logic                    carry;
	instr_u                  instr;
	instr_u                  fetched;
	core_state_e             state;
	logic                    branch_taken;

	// byte on the bus during decode
	assign fetched = rdata;

	assign alu_a     = a;
	// immediate and read-through-B both take the operand from the bus
	assign alu_b     = instr.compute.cls[0] ? rdata : b;
	assign alu_carry = carry;
	assign alu_op    = instr.compute.op;

	// arg is {zero value, zero enable, carry value, carry enable}
	assign branch_taken =
		(fetched.control.arg[0] && (fetched.control.arg[1] == carry)) ||
		(fetched.control.arg[2] && (fetched.control.arg[3] == zero));

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= st_restart;
			we    <= 1'b0;
			zero  <= 1'b0;
			carry <= 1'b0;
		end else begin
			case (state)
				st_restart: begin
					ip    <= `CPU8_RESET_VECTOR;
					we    <= 1'b0;
					state <= st_select;
				end
				// put IP on the bus, the opcode is there next cycle
				st_select: begin
					addr  <= ip;
					ip    <= ip + 1'b1;
					we    <= 1'b0;
					state <= st_decode;
				end
				st_decode: begin
					instr <= fetched;
					state <= st_select;
					case (fetched.compute.cls)
						// A op B
						2'b00: begin
							state <= st_compute;
						end
						// A op immediate
						2'b01: begin
							addr  <= ip;
							ip    <= ip + 1'b1;
							state <= st_compute;
						end
						// A op [B]
						2'b11: begin
							addr  <= b;
							state <= st_compute;
						end
						default: begin
							case (fetched.control.group)
								// store A, write happens during the next select
								4'b1001: begin
									addr <= {{(`CPU8_DATA_W-4){1'b0}}, fetched.control.arg};
									wdata <= a;
									we    <= 1'b1;
								end
								// target byte follows the branch opcode
								4'b1010: begin
									ip <= ip + 1'b1;
									if (branch_taken) begin
										addr  <= ip;
										state <= st_read_ip;
									end
								end
								4'b1000: begin
									if (fetched.control.arg == 4'b0001) begin
										a <= b;
										b <= a;
									end else if (fetched.control.arg == 4'b1000) begin
										carry <= 1'b0;
									end else begin
										state <= st_restart;
									end
								end
								// undefined bytes restart the program
								default: begin
									state <= st_restart;
								end
							endcase
						end
					endcase
				end
				st_compute: begin
					case (instr.compute.dest)
						dest_a:    a  <= alu_result[`CPU8_DATA_W-1:0];
						dest_b:    b  <= alu_result[`CPU8_DATA_W-1:0];
						dest_ip:   ip <= alu_result[`CPU8_DATA_W-1:0];
						dest_none: ;
					endcase
					// only ops 4-7 and 12-15 touch carry
					if (instr.compute.op[2]) begin
						carry <= alu_result[`CPU8_DATA_W];
					end
					zero  <= ~|alu_result[`CPU8_DATA_W-1:0];
					state <= st_select;
				end
				st_read_ip: begin
					ip    <= rdata;
					state <= st_select;
				end
				default: begin
					state <= st_restart;
				end
			endcase
		end
	end

endmodule

// File: hw/cpu8_pkg.sv
// shared types of the CPU; ALU operations, destinations, sequencer states and instruction views
package cpu8_pkg;

	// ALU operations, bit 2 set means the op produces carry
	typedef enum logic [3:0] {
		alu_zero   = 4'h0,
		alu_load_a = 4'h1,
		alu_inc    = 4'h2,
		alu_dec    = 4'h3,
		alu_asl    = 4'h4,
		alu_lsr    = 4'h5,
		alu_rol    = 4'h6,
		alu_ror    = 4'h7,
		alu_or     = 4'h8,
		alu_and    = 4'h9,
		alu_xor    = 4'ha,
		alu_load_b = 4'hb,
		alu_add    = 4'hc,
		alu_sub    = 4'hd,
		alu_adc    = 4'he,
		alu_sbb    = 4'hf
	} alu_op_e;

	// where a compute result goes
	typedef enum logic [1:0] {
		dest_a    = 2'b00,
		dest_b    = 2'b01,
		dest_ip   = 2'b10,
		dest_none = 2'b11
	} dest_e;

	typedef enum logic [2:0] {
		st_restart = 3'd0,
		st_select  = 3'd1,
		st_decode  = 3'd2,
		st_compute = 3'd3,
		st_read_ip = 3'd4
	} core_state_e;

	// class 00 uses B, 01 the immediate byte, 11 the byte at [B]
	typedef struct packed {
		logic [1:0] cls;
		dest_e      dest;
		alu_op_e    op;
	} compute_view_t;

	// class 10 only: 1000 swap/clear-carry, 1001 store, 1010 branch
	typedef struct packed {
		logic [3:0] group;
		logic [3:0] arg;
	} control_view_t;

	typedef union packed {
		compute_view_t compute;
		control_view_t control;
	} instr_u;

endpackage

// File: hw/cpu8_ram.sv
// single-port program and data RAM with combinational read and a separate program load port
`timescale 1ns/1ps
`include "cpu8_config.svh"

module cpu8_ram (
	input  logic                    clk,
	input  logic [`CPU8_DATA_W-1:0] addr,
	input  logic [`CPU8_DATA_W-1:0] wdata,
	input  logic                    we,
	output logic [`CPU8_DATA_W-1:0] rdata,
	input  logic                    load_en,
	input  logic [`CPU8_DATA_W-1:0] load_addr,
	input  logic [`CPU8_DATA_W-1:0] load_data
);

	logic [`CPU8_DATA_W-1:0] mem [`CPU8_MEM_DEPTH];

	// read data follows addr in the same cycle
	assign rdata = mem[addr];

	always_ff @(posedge clk) begin
		// loader wins over a core store in the same cycle
		if (load_en) begin
			mem[load_addr] <= load_data;
		end else if (we) begin
			mem[addr] <= wdata;
		end
	end

endmodule

// File: hw/cpu8_top.sv
// top level of the CPU; core, ALU and RAM, with the program load port and the store bus outside
`timescale 1ns/1ps
`include "cpu8_config.svh"

module cpu8_top (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    load_en,
	input  logic [`CPU8_DATA_W-1:0] load_addr,
	input  logic [`CPU8_DATA_W-1:0] load_data,
	output logic [`CPU8_DATA_W-1:0] mem_addr,
	output logic [`CPU8_DATA_W-1:0] mem_wdata,
	output logic                    mem_write
);
	import cpu8_pkg::*;

	logic [`CPU8_DATA_W-1:0] rdata;
	logic [`CPU8_DATA_W-1:0] alu_a;
	logic [`CPU8_DATA_W-1:0] alu_b;
	logic                    alu_carry;
	alu_op_e                 alu_op;
	logic [`CPU8_DATA_W:0]   alu_result;

	// core bus doubles as the visible store bus
	cpu8_core u_core (
		.clk        (clk),
		.reset      (reset),
		.rdata      (rdata),
		.addr       (mem_addr),
		.wdata      (mem_wdata),
		.we         (mem_write),
		.alu_a      (alu_a),
		.alu_b      (alu_b),
		.alu_carry  (alu_carry),
		.alu_op     (alu_op),
		.alu_result (alu_result)
	);

	cpu8_alu #(
		.width (`CPU8_DATA_W)
	) u_alu (
		.a        (alu_a),
		.b        (alu_b),
		.carry_in (alu_carry),
		.op       (alu_op),
		.result   (alu_result)
	);

	cpu8_ram u_ram (
		.clk       (clk),
		.addr      (mem_addr),
		.wdata     (mem_wdata),
		.we        (mem_write),
		.rdata     (rdata),
		.load_en   (load_en),
		.load_addr (load_addr),
		.load_data (load_data)
	);

endmodule

// File: include/cpu8_config.svh
// build parameters for the 8-bit accumulator CPU, included by the RTL and the testbench
`ifndef CPU8_CONFIG_SVH
`define CPU8_CONFIG_SVH

// data path and address width
`define CPU8_DATA_W 8

// IP value loaded by the restart state
`define CPU8_RESET_VECTOR 8'h80

// bytes in the single RAM, one per address
`define CPU8_MEM_DEPTH 256

// store instructions carry a 4-bit address
`define CPU8_STORE_LIMIT 16

`endif

// File: sim/cpu8_props.sv
// concurrent checks on the core store strobe and sequencer flow, bound into every cpu8_core
`timescale 1ns/1ps

module cpu8_props (
	input logic                  clk,
	input logic                  reset,
	input logic                  we,
	input cpu8_pkg::core_state_e state
);
	import cpu8_pkg::*;

	// a store strobe lasts one cycle
	we_single_cycle: assert property (@(posedge clk) disable iff (reset)
		we |=> !we)
		else $error("store strobe high in two consecutive cycles");

	select_then_decode: assert property (@(posedge clk) disable iff (reset)
		(state == st_select) |=> (state == st_decode))
		else $error("select state not followed by decode");

	// strobe cleared by reset
	we_low_after_reset: assert property (@(posedge clk)
		reset |=> !we)
		else $error("store strobe not low in the cycle after reset");

endmodule

bind cpu8_core cpu8_props u_props (
	.clk   (clk),
	.reset (reset),
	.we    (we),
	.state (state)
);

// File: sim/cpu8_tb.sv
// self-checking testbench for cpu8_top; random programs run against an instruction-level model
`timescale 1ns/1ps
`include "cpu8_config.svh"

module cpu8_tb;

	localparam int num_programs = 12;
	localparam int max_instr = 32;

	logic       clk;
	logic       reset;
	logic       load_en;
	logic [7:0] load_addr;
	logic [7:0] load_data;
	logic [7:0] mem_addr;
	logic [7:0] mem_wdata;
	logic       mem_write;

	logic [7:0] img [`CPU8_MEM_DEPTH];
	logic [7:0] exp_addr_q [$];
	logic [7:0] exp_data_q [$];
	int         exec_count;
	int         run_limit;
	int         run_cycles;
	int         stores_seen;
	int         errors;
	int         checks;
	bit         running;

	cpu8_top UUT (
		.clk       (clk),
		.reset     (reset),
		.load_en   (load_en),
		.load_addr (load_addr),
		.load_data (load_data),
		.mem_addr  (mem_addr),
		.mem_wdata (mem_wdata),
		.mem_write (mem_write)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// 9-bit ALU result with carry, borrow or the shifted-out bit on top
	function automatic logic [8:0] alu_ref(input logic [3:0] op, input logic [7:0] x,
		input logic [7:0] y, input logic cin);
		int sum;
		int diff;
		logic [8:0] r;
		sum = int'(x) + int'(y) + (op[1] ? int'(cin) : 0);
		diff = int'(x) - int'(y) - (op[1] ? int'(cin) : 0);
		case (op)
			4'h0: r = 9'h000;
			4'h1: r = {1'b0, x};
			4'h2: r = {1'b0, 8'(x + 8'd1)};
			4'h3: r = {1'b0, 8'(x - 8'd1)};
			4'h4: r = {x[7], x[6:0], 1'b0};
			4'h5: r = {x[0], 1'b0, x[7:1]};
			4'h6: r = {x[7], x[6:0], cin};
			4'h7: r = {x[0], cin, x[7:1]};
			4'h8: r = {1'b0, x | y};
			4'h9: r = {1'b0, x & y};
			4'ha: r = {1'b0, x ^ y};
			4'hb: r = {1'b0, y};
			4'hc, 4'he: r = {sum > 255, 8'(sum)};
			default: r = {diff < 0, 8'(diff)};
		endcase
		return r;
	endfunction

	// random destination of A, B or none but never IP
	function automatic logic [1:0] pick_dest();
		logic [1:0] d;
		d = 2'($urandom);
		return (d == 2'b10) ? 2'b00 : d;
	endfunction

	task automatic build_program(output logic [7:0] jump_addr);
		int kind [max_instr];
		logic [7:0] at [max_instr + 1];
		int n;
		int pc;
		int j;
		for (int i = 0; i < `CPU8_MEM_DEPTH; i++) begin
			img[i] = 8'(i * 29) ^ 8'hc3;
		end
		n = 12 + $urandom % 18;
		pc = `CPU8_RESET_VECTOR;
		for (int i = 0; i < n; i++) begin
			kind[i] = (i < 2) ? 10 : $urandom % 10;
			at[i] = 8'(pc);
			pc += (kind[i] inside {3, 4, 9, 10}) ? 2 : 1;
		end
		at[n] = 8'(pc);
		for (int i = 0; i < n; i++) begin
			case (kind[i])
				0, 1, 2: img[at[i]] = {2'b00, pick_dest(), 4'($urandom)};
				3, 4: img[at[i]] = {2'b01, pick_dest(), 4'($urandom)};
				5: img[at[i]] = {2'b11, pick_dest(), 4'($urandom)};
				6, 7: img[at[i]] = {4'b1001, 4'($urandom % `CPU8_STORE_LIMIT)};
				8: img[at[i]] = ($urandom % 2) ? 8'h81 : 8'h88;
				9: begin
					j = i + 1 + $urandom % (n - i);
					img[at[i]] = {4'b1010, 4'($urandom)};
					img[at[i] + 1] = at[j];
				end
				// load A and then B with an immediate
				default: img[at[i]] = (i == 0) ? 8'h4b : 8'h5b;
			endcase
			if (kind[i] inside {3, 4, 10}) begin
				img[at[i] + 1] = 8'($urandom);
			end
			// B starts inside the store window so reads through B see stored bytes
			if (i == 1) begin
				img[at[i] + 1] = 8'($urandom % `CPU8_STORE_LIMIT);
			end
		end
		img[at[n]] = 8'h6b;
		img[at[n] + 1] = at[n];
		jump_addr = at[n];
	endtask

	task automatic run_model(input logic [7:0] jump_addr);
		logic [7:0] mm [`CPU8_MEM_DEPTH];
		logic [7:0] ip;
		logic [7:0] a;
		logic [7:0] b;
		logic [7:0] opc;
		logic [7:0] operand;
		logic [8:0] res;
		logic zf;
		logic cf;
		mm = img;
		ip = `CPU8_RESET_VECTOR;
		a = 8'h00;
		b = 8'h00;
		zf = 1'b0;
		cf = 1'b0;
		exec_count = 1;
		exp_addr_q.delete();
		exp_data_q.delete();
		while (ip != jump_addr && exec_count < 1000) begin
			opc = mm[ip];
			exec_count++;
			if (opc[7:4] == 4'b1001) begin
				mm[opc[3:0]] = a;
				exp_addr_q.push_back({4'h0, opc[3:0]});
				exp_data_q.push_back(a);
				ip = ip + 8'd1;
			end else if (opc[7:4] == 4'b1010) begin
				if ((opc[0] && opc[1] == cf) || (opc[2] && opc[3] == zf)) begin
					ip = mm[8'(ip + 1)];
				end else begin
					ip = ip + 8'd2;
				end
			end else if (opc[7:6] == 2'b10) begin
				if (opc[3:0] == 4'b0001) begin
					{a, b} = {b, a};
				end else begin
					cf = 1'b0;
				end
				ip = ip + 8'd1;
			end else begin
				// operand from B, the immediate byte or the byte at [B]
				operand = (opc[7:6] == 2'b00) ? b : (opc[7:6] == 2'b01) ? mm[8'(ip + 1)] : mm[b];
				ip = ip + ((opc[7:6] == 2'b01) ? 8'd2 : 8'd1);
				res = alu_ref(opc[3:0], a, operand, cf);
				if (opc[5:4] == 2'b00) begin
					a = res[7:0];
				end else if (opc[5:4] == 2'b01) begin
					b = res[7:0];
				end
				if (opc[2]) begin
					cf = res[8];
				end
				zf = (res[7:0] == 8'h00);
			end
		end
	endtask

	// program is written through the load port while reset is held
	task automatic load_program();
		reset <= 1'b1;
		repeat (4) @(posedge clk);
		for (int i = 0; i < `CPU8_MEM_DEPTH; i++) begin
			load_en <= 1'b1;
			load_addr <= 8'(i);
			load_data <= img[i];
			@(posedge clk);
		end
		load_en <= 1'b0;
	endtask

	// store monitor sampling outputs on the falling edge
	always @(negedge clk) begin
		if (running) begin
			run_cycles = run_cycles + 1;
			if (mem_write) begin
				assert (stores_seen < exp_addr_q.size()) else begin
					errors = errors + 1;
					$display("extra store at %0t: [%h] = %h after all %0d expected stores",
						$time, mem_addr, mem_wdata, exp_addr_q.size());
				end
				if (stores_seen < exp_addr_q.size()) begin
					checks = checks + 1;
					assert (mem_addr == exp_addr_q[stores_seen] &&
						mem_wdata == exp_data_q[stores_seen]) else begin
						errors = errors + 1;
						$display("CHECK FAILED at %0t: store %0d expected [%h] = %h, got [%h] = %h",
							$time, stores_seen, exp_addr_q[stores_seen],
							exp_data_q[stores_seen], mem_addr, mem_wdata);
					end
				end
				stores_seen = stores_seen + 1;
			end
			if (run_cycles > run_limit && stores_seen < exp_addr_q.size()) begin
				errors = errors + 1;
				$display("timeout: only %0d of %0d expected stores seen after %0d cycles",
					stores_seen, exp_addr_q.size(), run_cycles);
				$display("checks: %0d, errors: %0d", checks, errors);
				$display("TEST FAILED");
				$finish;
			end
		end
	end

	initial begin
		logic [7:0] jump_addr;
		void'($urandom(32'h1bbb19ed));
		reset = 1'b1;
		load_en = 1'b0;
		load_addr = 8'h00;
		load_data = 8'h00;
		running = 1'b0;
		errors = 0;
		checks = 0;
		run_cycles = 0;
		stores_seen = 0;
		run_limit = 0;
		for (int p = 0; p < num_programs; p++) begin
			build_program(jump_addr);
			run_model(jump_addr);
			load_program();
			run_cycles = 0;
			stores_seen = 0;
			run_limit = 3 * exec_count + 20;
			@(posedge clk);
			reset <= 1'b0;
			running <= 1'b1;
			while (stores_seen < exp_addr_q.size()) @(posedge clk);
			// keep watching until the final jump for stray stores
			while (run_cycles < run_limit) @(posedge clk);
			running <= 1'b0;
			reset <= 1'b1;
		end
		@(posedge clk);
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

// File: src.f
+incdir+include
hw/cpu8_pkg.sv
hw/cpu8_alu.sv
hw/cpu8_core.sv
hw/cpu8_ram.sv
hw/cpu8_top.sv
sim/cpu8_props.sv
sim/cpu8_tb.sv
